/* design/smartnic_cfg.svh */
`ifndef SMARTNIC_CFG_SVH
`define SMARTNIC_CFG_SVH

// ====================
// Datapath geometry
// ====================

// Bytes carried per stream beat
`define SN_DATA_BYTES 8

// Ports 0-1 network, ports 2-3 host
`define SN_NUM_PORTS 4

// ====================
// Buffering
// ====================

// Beats held per ingress buffer
`define SN_FIFO_DEPTH 64

// Longest packet in beats, kept within one buffer
`define SN_MAX_PKT_BEATS 16

`endif

/* design/smartnic_pkg.sv */
`default_nettype none

`include "smartnic_cfg.svh"

package smartnic_pkg;

    // ====================
    // Width types
    // ====================

    // Port number, used for tid and tdest
    typedef logic [$clog2(`SN_NUM_PORTS)-1:0] port_t;

    typedef logic [`SN_DATA_BYTES*8-1:0] data_t;

    // One enable per data byte
    typedef logic [`SN_DATA_BYTES-1:0] keep_t;

    // One bit per port, for requests, grants and handshakes
    typedef logic [`SN_NUM_PORTS-1:0] port_mask_t;

    // ====================
    // Stream beat
    // ====================

    // tid ignored at ingress, source port at egress
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        port_t tid;
        port_t tdest;
    } axis_beat_t;

    // Egress arbiter FSM
    typedef enum logic [0:0] {
        IDLE,
        BUSY
    } arb_state_e;

endpackage

`default_nettype wire

/* design/pkt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module pkt_fifo (
    input  wire logic                     axis_clk,
    input  wire logic                     rst_n,

    input  wire logic                     in_valid,
    input  smartnic_pkg::axis_beat_t      in_beat,
    output logic                          in_ready,

    output logic                          head_valid,
    output smartnic_pkg::axis_beat_t      head_beat,
    input  wire logic                     pop
);

    localparam int DEPTH = `SN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    localparam ptr_t PTR_LAST = ptr_t'(DEPTH - 1);

    // A packet longer than the buffer could never complete
    if (`SN_MAX_PKT_BEATS > `SN_FIFO_DEPTH) begin : g_depth_check
        $error("pkt_fifo: SN_MAX_PKT_BEATS exceeds SN_FIFO_DEPTH");
    end

    smartnic_pkg::axis_beat_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t beat_cnt;
    cnt_t pkt_cnt;

    logic wr_en;
    logic rd_en;
    logic pkt_in;
    logic pkt_out;

    // ====================
    // Handshakes
    // ====================

    assign in_ready = (beat_cnt != cnt_t'(DEPTH));
    assign wr_en    = in_valid && in_ready;

    // Head only offered once a whole packet sits in the buffer
    assign head_valid = (pkt_cnt != '0);
    assign head_beat  = mem[rd_ptr];
    assign rd_en      = pop && head_valid;

    assign pkt_in  = wr_en && in_beat.last;
    assign pkt_out = rd_en && head_beat.last;

    // ====================
    // Storage
    // ====================

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            beat_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   beat_cnt <= beat_cnt + 1'b1;
                2'b01:   beat_cnt <= beat_cnt - 1'b1;
                default: beat_cnt <= beat_cnt;
            endcase
        end
    end

    // Complete packets waiting, counted on tlast in and out
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else begin
            case ({pkt_in, pkt_out})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/egress_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module egress_arbiter (
    input  wire logic                     axis_clk,
    input  wire logic                     rst_n,

    input  smartnic_pkg::port_mask_t      req,
    input  smartnic_pkg::axis_beat_t      src_beat [`SN_NUM_PORTS],

    output logic                          out_valid,
    output smartnic_pkg::axis_beat_t      out_beat,
    input  wire logic                     out_ready,

    output smartnic_pkg::port_mask_t      grant
);

    localparam smartnic_pkg::port_t PORT_LAST = smartnic_pkg::port_t'(`SN_NUM_PORTS - 1);

    smartnic_pkg::arb_state_e state;
    smartnic_pkg::arb_state_e state_nxt;

    // Source served most recently, round-robin starts after it
    smartnic_pkg::port_t last_idx;
    // Source held for the packet in flight
    smartnic_pkg::port_t lock_idx;

    smartnic_pkg::port_t rr_idx;
    logic                rr_any;
    smartnic_pkg::port_t sel_idx;
    logic                sel_vld;
    logic                accept;

    // ====================
    // Round-robin pick
    // ====================

    always_comb begin : rr_pick
        smartnic_pkg::port_t cand;
        rr_any = 1'b0;
        rr_idx = last_idx;
        cand   = last_idx;
        for (int k = 0; k < `SN_NUM_PORTS; k++) begin
            cand = (cand == PORT_LAST) ? '0 : cand + 1'b1;
            if (!rr_any && req[cand]) begin
                rr_any = 1'b1;
                rr_idx = cand;
            end
        end
    end

    // Locked source wins while a packet is in flight
    always_comb begin
        if (state == smartnic_pkg::BUSY) begin
            sel_idx = lock_idx;
            sel_vld = req[lock_idx];
        end else begin
            sel_idx = rr_idx;
            sel_vld = rr_any;
        end
    end

    // ====================
    // Output mux
    // ====================

    assign out_valid = sel_vld;
    assign accept    = sel_vld && out_ready;

    always_comb begin
        out_beat     = src_beat[sel_idx];
        // Egress tid names the source port
        out_beat.tid = sel_idx;
    end

    always_comb begin
        grant = '0;
        if (sel_vld) begin
            grant[sel_idx] = 1'b1;
        end
    end

    // ====================
    // Packet lock FSM
    // ====================

    always_comb begin
        state_nxt = state;
        case (state)
            smartnic_pkg::IDLE: begin
                // Lock once offered, unless a single-beat packet goes straight out
                if (sel_vld && !(accept && out_beat.last)) begin
                    state_nxt = smartnic_pkg::BUSY;
                end
            end
            smartnic_pkg::BUSY: begin
                if (accept && out_beat.last) begin
                    state_nxt = smartnic_pkg::IDLE;
                end
            end
            default: state_nxt = smartnic_pkg::IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= smartnic_pkg::IDLE;
            lock_idx <= '0;
            last_idx <= PORT_LAST;
        end else begin
            state <= state_nxt;
            if (state == smartnic_pkg::IDLE && sel_vld) begin
                lock_idx <= sel_idx;
                last_idx <= sel_idx;
            end
        end
    end

endmodule

`default_nettype wire

/* design/switch_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module switch_crossbar (
    input  wire logic                     axis_clk,
    input  wire logic                     rst_n,

    input  smartnic_pkg::port_mask_t      head_valid,
    input  smartnic_pkg::axis_beat_t      head_beat [`SN_NUM_PORTS],
    output smartnic_pkg::port_mask_t      pop,

    output smartnic_pkg::port_mask_t      out_valid,
    output smartnic_pkg::axis_beat_t      out_beat [`SN_NUM_PORTS],
    input  smartnic_pkg::port_mask_t      out_ready
);

    // Grant row per egress, bit i set when source i owns it
    smartnic_pkg::port_mask_t grant_row [`SN_NUM_PORTS];

    // ====================
    // Egress arbiters
    // ====================

    for (genvar j = 0; j < `SN_NUM_PORTS; j++) begin : g_egress
        smartnic_pkg::port_mask_t req;

        // Sources whose head packet targets egress j
        always_comb begin
            for (int i = 0; i < `SN_NUM_PORTS; i++) begin
                req[i] = head_valid[i] &&
                         (head_beat[i].tdest == smartnic_pkg::port_t'(j));
            end
        end

        egress_arbiter u_egress_arbiter (
            .axis_clk  (axis_clk),
            .rst_n     (rst_n),
            .req       (req),
            .src_beat  (head_beat),
            .out_valid (out_valid[j]),
            .out_beat  (out_beat[j]),
            .out_ready (out_ready[j]),
            .grant     (grant_row[j])
        );
    end

    // Each source requests one egress only, so at most one term fires
    always_comb begin
        pop = '0;
        for (int i = 0; i < `SN_NUM_PORTS; i++) begin
            for (int j = 0; j < `SN_NUM_PORTS; j++) begin
                if (grant_row[j][i] && out_ready[j]) begin
                    pop[i] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/smartnic_switch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module smartnic_switch (
    input  wire logic                     axis_clk,
    input  wire logic                     rst_n,

    // Ports 0-1 network ingress, 2-3 host-to-card
    input  smartnic_pkg::port_mask_t      in_valid,
    input  smartnic_pkg::axis_beat_t      in_beat [`SN_NUM_PORTS],
    output smartnic_pkg::port_mask_t      in_ready,

    // Ports 0-1 network egress, 2-3 card-to-host
    output smartnic_pkg::port_mask_t      out_valid,
    output smartnic_pkg::axis_beat_t      out_beat [`SN_NUM_PORTS],
    input  smartnic_pkg::port_mask_t      out_ready
);

    smartnic_pkg::port_mask_t head_valid;
    smartnic_pkg::axis_beat_t head_beat [`SN_NUM_PORTS];
    smartnic_pkg::port_mask_t pop;

    // ====================
    // Ingress buffers
    // ====================

    for (genvar i = 0; i < `SN_NUM_PORTS; i++) begin : g_ingress
        pkt_fifo u_pkt_fifo (
            .axis_clk   (axis_clk),
            .rst_n      (rst_n),
            .in_valid   (in_valid[i]),
            .in_beat    (in_beat[i]),
            .in_ready   (in_ready[i]),
            .head_valid (head_valid[i]),
            .head_beat  (head_beat[i]),
            .pop        (pop[i])
        );
    end

    // ====================
    // Switching
    // ====================

    switch_crossbar u_switch_crossbar (
        .axis_clk   (axis_clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_beat  (head_beat),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* testbench/smartnic_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module smartnic_properties (
    input  wire logic                 axis_clk,
    input  wire logic                 rst_n,
    input  smartnic_pkg::port_mask_t  in_valid,
    input  smartnic_pkg::axis_beat_t  in_beat [`SN_NUM_PORTS],
    input  smartnic_pkg::port_mask_t  in_ready,
    input  smartnic_pkg::port_mask_t  out_valid,
    input  smartnic_pkg::axis_beat_t  out_beat [`SN_NUM_PORTS],
    input  smartnic_pkg::port_mask_t  out_ready
);

    // ====================
    // Reset state
    // ====================

    a_reset_quiet: assert property (@(posedge axis_clk)
        !rst_n |-> (out_valid == '0 && in_ready == '1))
        else $error("Egress valid or ingress ready wrong during reset");

    a_reset_exit: assert property (@(posedge axis_clk)
        $rose(rst_n) |-> (out_valid == '0 && in_ready == '1))
        else $error("Egress valid or ingress ready wrong after reset");

    for (genvar j = 0; j < `SN_NUM_PORTS; j++) begin : g_port
        a_no_gap: assert property (@(posedge axis_clk) disable iff (!rst_n)
            (out_valid[j] && !out_beat[j].last) |=> out_valid[j])
            else $error("Valid gap inside a packet on egress %0d", j);

        a_hold_valid: assert property (@(posedge axis_clk) disable iff (!rst_n)
            (out_valid[j] && !out_ready[j]) |=> out_valid[j])
            else $error("Egress %0d dropped valid under back-pressure", j);

        // Offered beat stays put until taken, first beat included
        a_hold_beat: assert property (@(posedge axis_clk) disable iff (!rst_n)
            (out_valid[j] && !out_ready[j]) |=> $stable(out_beat[j]))
            else $error("Egress %0d changed a beat under back-pressure", j);

        a_in_hold: assert property (@(posedge axis_clk) disable iff (!rst_n)
            (in_valid[j] && !in_ready[j]) |=> (in_valid[j] && $stable(in_beat[j])))
            else $error("Ingress %0d source broke the handshake", j);
    end

endmodule

bind smartnic_switch smartnic_properties u_smartnic_properties (
    .axis_clk  (axis_clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
);

`default_nettype wire

/* testbench/tb_smartnic_switch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_cfg.svh"

module tb_smartnic_switch;

    localparam int NUM          = `SN_NUM_PORTS;
    localparam int NUM_PKTS     = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 2 * `SN_MAX_PKT_BEATS;
    localparam int DRAIN_LIMIT  = NUM * `SN_FIFO_DEPTH * 8;
    localparam int WATCHDOG_CYCLES =
        4 * NUM_PKTS * `SN_MAX_PKT_BEATS * 8 + RESET_CYCLES;

    typedef logic [63:0] word_t;

    logic                     axis_clk;
    logic                     rst_n;
    smartnic_pkg::port_mask_t in_valid;
    smartnic_pkg::axis_beat_t in_beat [NUM];
    smartnic_pkg::port_mask_t in_ready;
    smartnic_pkg::port_mask_t out_valid;
    smartnic_pkg::axis_beat_t out_beat [NUM];
    smartnic_pkg::port_mask_t out_ready;

    int seed;
    int errors;
    int pending;
    int beats_seen;

    // Expected beats per source and destination, index src * NUM + dst
    smartnic_pkg::axis_beat_t exp_q [NUM*NUM][$];

    smartnic_switch u_smartnic_switch (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    always #10 axis_clk = ~axis_clk;

    // ====================
    // Helpers
    // ====================

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Contiguous byte enables from byte 0 upward
    function automatic smartnic_pkg::keep_t low_mask(input int n);
        return smartnic_pkg::keep_t'((16'd1 << n) - 16'd1);
    endfunction

    // ====================
    // Ingress driver
    // ====================

    task automatic send_port(input int p);
        smartnic_pkg::axis_beat_t beat;
        smartnic_pkg::port_t      dest;
        int                       len;
        int                       gap;
        for (int n = 0; n < NUM_PKTS; n++) begin
            len  = 1 + rand_below(`SN_MAX_PKT_BEATS);
            dest = smartnic_pkg::port_t'(rand_below(NUM));
            for (int b = 0; b < len; b++) begin
                // Idle now and then between beats
                gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
                repeat (gap) begin
                    @(negedge axis_clk);
                    in_valid[p] = 1'b0;
                end
                beat.data  = {$random(seed), $random(seed)};
                beat.last  = (b == len - 1);
                beat.keep  = beat.last ? low_mask(1 + rand_below(`SN_DATA_BYTES)) : '1;
                beat.tid   = '0;
                beat.tdest = dest;
                @(negedge axis_clk);
                in_valid[p] = 1'b1;
                in_beat[p]  = beat;
                #1;
                // in_ready is registered, so it holds until the next edge
                while (!in_ready[p]) begin
                    @(negedge axis_clk);
                    #1;
                end
                beat.tid = smartnic_pkg::port_t'(p);
                exp_q[p * NUM + int'(dest)].push_back(beat);
                pending++;
            end
        end
        @(negedge axis_clk);
        in_valid[p] = 1'b0;
    endtask

    // ====================
    // Egress monitor
    // ====================

    task automatic watch_egress();
        smartnic_pkg::axis_beat_t exp_beat;
        smartnic_pkg::port_mask_t open;
        int                       q;
        open = '0;
        forever begin
            @(negedge axis_clk);
            out_ready = smartnic_pkg::port_mask_t'($random(seed)) |
                        smartnic_pkg::port_mask_t'($random(seed));
            #1;
            for (int j = 0; j < NUM; j++) begin
                // Packet started on this egress must not pause
                if (open[j]) begin
                    compare("no_gap", word_t'(1), word_t'(out_valid[j]));
                end
                if (out_valid[j] && out_ready[j]) begin
                    q = int'(out_beat[j].tid) * NUM + j;
                    compare("routing", word_t'(1), word_t'(exp_q[q].size() != 0));
                    compare("tdest", word_t'(j), word_t'(out_beat[j].tdest));
                    if (exp_q[q].size() != 0) begin
                        exp_beat = exp_q[q].pop_front();
                        compare("data", word_t'(exp_beat.data), word_t'(out_beat[j].data));
                        compare("keep", word_t'(exp_beat.keep), word_t'(out_beat[j].keep));
                        compare("last", word_t'(exp_beat.last), word_t'(out_beat[j].last));
                        pending--;
                        beats_seen++;
                    end
                    open[j] = !out_beat[j].last;
                end
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin : main
        seed       = 85;
        errors     = 0;
        pending    = 0;
        beats_seen = 0;
        axis_clk   = 1'b0;
        rst_n      = 1'b0;
        in_valid   = '0;
        out_ready  = '0;
        for (int i = 0; i < NUM; i++) begin
            in_beat[i] = '0;
        end

        repeat (RESET_CYCLES) @(negedge axis_clk);
        compare("reset_out_valid", word_t'(0), word_t'(out_valid));
        compare("reset_in_ready", word_t'(4'hf), word_t'(in_ready));
        rst_n = 1'b1;
        #1;
        compare("post_reset_out_valid", word_t'(0), word_t'(out_valid));
        compare("post_reset_in_ready", word_t'(4'hf), word_t'(in_ready));

        fork
            watch_egress();
        join_none

        fork
            send_port(0);
            send_port(1);
            send_port(2);
            send_port(3);
        join

        // Buffered beats get a bounded time to come out
        for (int c = 0; c < DRAIN_LIMIT && pending != 0; c++) begin
            @(negedge axis_clk);
        end
        // Let any stray extra beat show up
        repeat (DRAIN_CYCLES) @(negedge axis_clk);
        for (int q = 0; q < NUM * NUM; q++) begin
            compare("drain", word_t'(0), word_t'(exp_q[q].size()));
        end

        $display("Summary: %0d beats checked, %0d errors", beats_seen, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        $display("Timeout: traffic did not drain within %0d cycles", WATCHDOG_CYCLES);
        $display("Summary: %0d beats checked, %0d errors", beats_seen, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/smartnic_pkg.sv
design/pkt_fifo.sv
design/egress_arbiter.sv
design/switch_crossbar.sv
design/smartnic_switch.sv
testbench/smartnic_properties.sv
testbench/tb_smartnic_switch.sv

/* run.sh */
#!/bin/sh
# Compile and run the switch testbench with Verilator

set -u

LOG=sim.log
TOP=tb_smartnic_switch

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module "$TOP" --Mdir obj_dir -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0
